//--- rtl/align_ram_macros.svh
`ifndef ALIGN_RAM_MACROS_SVH
`define ALIGN_RAM_MACROS_SVH

// Data word
`define ALIGN_WIDTH 32

// Row geometry. Words per row must stay a power of two
`define ALIGN_NUMWRDS 4
`define ALIGN_BITWRDS 2
`define ALIGN_NUMSROW 256
`define ALIGN_BITSROW 8

// Flat word address is {row, word}
`define ALIGN_BITADDR 10

// Cycles from read request to row data at the memory output
`define ALIGN_SRAM_DELAY 2

`endif

//--- rtl/align_ram_pkg.sv
`include "align_ram_macros.svh"

package align_ram_pkg;

  typedef logic [`ALIGN_WIDTH-1:0] word_t;
  typedef logic [`ALIGN_BITSROW-1:0] row_t;
  typedef logic [`ALIGN_BITWRDS-1:0] wsel_t;

  // One full row of data, also used as a row of bit enables
  typedef logic [`ALIGN_NUMWRDS*`ALIGN_WIDTH-1:0] row_data_t;

  typedef struct packed {
    row_t  row;   // High bits select the memory row
    wsel_t word;  // Low bits select the word inside the row
  } addr_fields_t;

  // Same address seen flat by the caller and split by the memory
  typedef union packed {
    logic [`ALIGN_BITADDR-1:0] flat;
    addr_fields_t              f;
  } addr_u;

endpackage

//--- rtl/write_cache.sv
`timescale 1ns/100ps
`include "align_ram_macros.svh"

module write_cache (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     write_0,
  input  logic                     write_1,
  input  logic                     read_0,
  input  logic                     read_1,
  input  align_ram_pkg::addr_u     addr_0,
  input  align_ram_pkg::addr_u     addr_1,
  input  align_ram_pkg::word_t     din_0,
  input  align_ram_pkg::word_t     din_1,
  output logic                     mem_write_0,
  output logic                     mem_write_1,
  output logic                     mem_read_0,
  output logic                     mem_read_1,
  output align_ram_pkg::row_t      mem_addr_0,
  output align_ram_pkg::row_t      mem_addr_1,
  output align_ram_pkg::row_data_t mem_bw_0,
  output align_ram_pkg::row_data_t mem_bw_1,
  output align_ram_pkg::row_data_t mem_din_0,
  output align_ram_pkg::row_data_t mem_din_1,
  output logic                     fwd_0,
  output logic                     fwd_1,
  output align_ram_pkg::word_t     fwd_data_0,
  output align_ram_pkg::word_t     fwd_data_1
);

  align_ram_pkg::row_t      row_0;
  align_ram_pkg::row_t      row_1;
  align_ram_pkg::wsel_t     wsel_0;
  align_ram_pkg::wsel_t     wsel_1;

  logic                     same_row;
  logic                     cfl_0;    // Port 0 write blocked by a port 1 read of the row
  logic                     cfl_1;
  logic                     hit_0;
  logic                     hit_1;
  logic                     both_wr;
  logic                     ins_0;
  logic                     ins_1;

  // Write lanes and data of each request, already placed in the row
  align_ram_pkg::row_data_t bw_0;
  align_ram_pkg::row_data_t bw_1;
  align_ram_pkg::row_data_t dat_0;
  align_ram_pkg::row_data_t dat_1;

  logic                     cache_vld;
  align_ram_pkg::row_t      cache_row;
  logic [`ALIGN_NUMWRDS-1:0] cache_msk;
  align_ram_pkg::row_data_t cache_dat;
  align_ram_pkg::row_data_t cache_bw;

  logic                     nxt_vld;
  align_ram_pkg::row_t      nxt_row;
  logic [`ALIGN_NUMWRDS-1:0] nxt_msk;
  align_ram_pkg::row_data_t nxt_dat;

  function automatic align_ram_pkg::row_data_t word_mask(input align_ram_pkg::wsel_t sel);
    align_ram_pkg::row_data_t m;
    m = '0;
    m[sel*`ALIGN_WIDTH +: `ALIGN_WIDTH] = '1;
    return m;
  endfunction

  function automatic align_ram_pkg::row_data_t word_place(input align_ram_pkg::word_t w,
                                                          input align_ram_pkg::wsel_t sel);
    align_ram_pkg::row_data_t d;
    d = '0;
    d[sel*`ALIGN_WIDTH +: `ALIGN_WIDTH] = w;
    return d;
  endfunction

  assign row_0  = addr_0.f.row;
  assign row_1  = addr_1.f.row;
  assign wsel_0 = addr_0.f.word;
  assign wsel_1 = addr_1.f.word;

  assign bw_0  = word_mask(wsel_0);
  assign bw_1  = word_mask(wsel_1);
  assign dat_0 = word_place(din_0, wsel_0);
  assign dat_1 = word_place(din_1, wsel_1);

  assign same_row = (row_0 == row_1);
  assign cfl_0    = write_0 && read_1 && same_row;
  assign cfl_1    = write_1 && read_0 && same_row;
  assign both_wr  = write_0 && write_1 && same_row;
  assign hit_0    = cache_vld && (row_0 == cache_row);
  assign hit_1    = cache_vld && (row_1 == cache_row);

  // A write lands in the cache when deferred or when its row is the cached one
  assign ins_0 = write_0 && (cfl_0 || hit_0);
  assign ins_1 = write_1 && (cfl_1 || hit_1);

  always_comb begin
    for (int i = 0; i < `ALIGN_NUMWRDS; i++)
      cache_bw[i*`ALIGN_WIDTH +: `ALIGN_WIDTH] = {`ALIGN_WIDTH{cache_msk[i]}};
  end

  always_comb begin
    nxt_vld = cache_vld;
    nxt_row = cache_row;
    nxt_msk = cache_msk;
    nxt_dat = cache_dat;
    if (cfl_0 || cfl_1) begin
      nxt_vld = 1'b1;
      nxt_row = cfl_0 ? row_0 : row_1;
      if (!(cfl_0 ? hit_0 : hit_1))
        nxt_msk = '0;  // Old row leaves through the flush this cycle
    end
    if (ins_0) begin
      nxt_msk[wsel_0] = 1'b1;
      nxt_dat = (nxt_dat & ~bw_0) | dat_0;
    end
    if (ins_1) begin
      nxt_msk[wsel_1] = 1'b1;
      nxt_dat = (nxt_dat & ~bw_1) | dat_1;  // Port 1 wins on the same word
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cache_vld <= 1'b0;
      cache_msk <= '0;
    end else begin
      cache_vld <= nxt_vld;
      cache_msk <= nxt_msk;
    end
  end

  always_ff @(posedge clk) begin
    cache_row <= nxt_row;
    cache_dat <= nxt_dat;
  end

  // On a conflict the writing port is free to flush a different cached row
  assign mem_read_0  = read_0;
  assign mem_write_0 = cfl_0 ? (cache_vld && !hit_0) : (write_0 && !both_wr);
  assign mem_addr_0  = cfl_0 ? cache_row : row_0;
  assign mem_bw_0    = cfl_0 ? cache_bw : bw_0;
  assign mem_din_0   = cfl_0 ? cache_dat : dat_0;

  assign mem_read_1  = read_1;
  assign mem_write_1 = cfl_1 ? (cache_vld && !hit_1) : write_1;
  assign mem_addr_1  = cfl_1 ? cache_row : row_1;
  assign mem_bw_1    = cfl_1 ? cache_bw : (both_wr ? (bw_0 | bw_1) : bw_1);
  assign mem_din_1   = cfl_1 ? cache_dat : (both_wr ? ((dat_0 & ~bw_1) | dat_1) : dat_1);

  // Forwarding looks at the cache as it was before this edge
  assign fwd_0      = read_0 && hit_0 && cache_msk[wsel_0];
  assign fwd_1      = read_1 && hit_1 && cache_msk[wsel_1];
  assign fwd_data_0 = cache_dat[wsel_0*`ALIGN_WIDTH +: `ALIGN_WIDTH];
  assign fwd_data_1 = cache_dat[wsel_1*`ALIGN_WIDTH +: `ALIGN_WIDTH];

endmodule

//--- rtl/row_sram.sv
`timescale 1ns/100ps
`include "align_ram_macros.svh"

module row_sram (
  input  logic                     clk,
  input  logic                     mem_write_0,
  input  logic                     mem_write_1,
  input  logic                     mem_read_0,
  input  logic                     mem_read_1,
  input  align_ram_pkg::row_t      mem_addr_0,
  input  align_ram_pkg::row_t      mem_addr_1,
  input  align_ram_pkg::row_data_t mem_bw_0,
  input  align_ram_pkg::row_data_t mem_bw_1,
  input  align_ram_pkg::row_data_t mem_din_0,
  input  align_ram_pkg::row_data_t mem_din_1,
  output align_ram_pkg::row_data_t mem_dout_0,
  output align_ram_pkg::row_data_t mem_dout_1
);

  align_ram_pkg::row_data_t mem [`ALIGN_NUMSROW];

  align_ram_pkg::row_data_t rd_q_0 [`ALIGN_SRAM_DELAY];
  align_ram_pkg::row_data_t rd_q_1 [`ALIGN_SRAM_DELAY];

  // Bit enabled writes. Both ports never write the same row in one cycle
  always_ff @(posedge clk) begin
    if (mem_write_0)
      mem[mem_addr_0] <= (mem[mem_addr_0] & ~mem_bw_0) | (mem_din_0 & mem_bw_0);
    if (mem_write_1)
      mem[mem_addr_1] <= (mem[mem_addr_1] & ~mem_bw_1) | (mem_din_1 & mem_bw_1);
  end

  // First stage samples the row before this edge's writes
  always_ff @(posedge clk) begin
    if (mem_read_0)
      rd_q_0[0] <= mem[mem_addr_0];
    if (mem_read_1)
      rd_q_1[0] <= mem[mem_addr_1];
    for (int s = 1; s < `ALIGN_SRAM_DELAY; s++) begin
      rd_q_0[s] <= rd_q_0[s-1];
      rd_q_1[s] <= rd_q_1[s-1];
    end
  end

  assign mem_dout_0 = rd_q_0[`ALIGN_SRAM_DELAY-1];
  assign mem_dout_1 = rd_q_1[`ALIGN_SRAM_DELAY-1];

endmodule

//--- rtl/read_align.sv
`timescale 1ns/100ps
`include "align_ram_macros.svh"

module read_align (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     read,
  input  align_ram_pkg::addr_u     addr,
  input  logic                     fwd,
  input  align_ram_pkg::word_t     fwd_data,
  input  align_ram_pkg::row_data_t mem_dout,
  output align_ram_pkg::word_t     rd_dout,
  output logic                     rd_fwrd,
  output logic                     rd_vld
);

  localparam int LAST = `ALIGN_SRAM_DELAY - 1;

  logic [`ALIGN_SRAM_DELAY-1:0] vld_q;
  logic [`ALIGN_SRAM_DELAY-1:0] fwd_q;
  align_ram_pkg::wsel_t         wsel_q [`ALIGN_SRAM_DELAY];
  align_ram_pkg::word_t         dat_q  [`ALIGN_SRAM_DELAY];

  align_ram_pkg::word_t         mem_word;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= read;
      for (int s = 1; s < `ALIGN_SRAM_DELAY; s++)
        vld_q[s] <= vld_q[s-1];
    end
  end

  // Side information follows the valid bit so several reads can be in flight
  always_ff @(posedge clk) begin
    fwd_q[0]  <= fwd;
    wsel_q[0] <= addr.f.word;
    dat_q[0]  <= fwd_data;
    for (int s = 1; s < `ALIGN_SRAM_DELAY; s++) begin
      fwd_q[s]  <= fwd_q[s-1];
      wsel_q[s] <= wsel_q[s-1];
      dat_q[s]  <= dat_q[s-1];
    end
  end

  assign mem_word = mem_dout[wsel_q[LAST]*`ALIGN_WIDTH +: `ALIGN_WIDTH];

  assign rd_dout = fwd_q[LAST] ? dat_q[LAST] : mem_word;
  assign rd_fwrd = vld_q[LAST] && fwd_q[LAST];  // Forward chain has no reset
  assign rd_vld  = vld_q[LAST];

endmodule

//--- rtl/align_ram_2rw.sv
`timescale 1ns/100ps

module align_ram_2rw (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 write_0,
  input  logic                 read_0,
  input  align_ram_pkg::addr_u addr_0,
  input  align_ram_pkg::word_t din_0,
  input  logic                 write_1,
  input  logic                 read_1,
  input  align_ram_pkg::addr_u addr_1,
  input  align_ram_pkg::word_t din_1,
  output align_ram_pkg::word_t rd_dout_0,
  output logic                 rd_fwrd_0,
  output logic                 rd_vld_0,
  output align_ram_pkg::word_t rd_dout_1,
  output logic                 rd_fwrd_1,
  output logic                 rd_vld_1
);

  logic                     mem_write_0;
  logic                     mem_write_1;
  logic                     mem_read_0;
  logic                     mem_read_1;
  align_ram_pkg::row_t      mem_addr_0;
  align_ram_pkg::row_t      mem_addr_1;
  align_ram_pkg::row_data_t mem_bw_0;
  align_ram_pkg::row_data_t mem_bw_1;
  align_ram_pkg::row_data_t mem_din_0;
  align_ram_pkg::row_data_t mem_din_1;
  align_ram_pkg::row_data_t mem_dout_0;
  align_ram_pkg::row_data_t mem_dout_1;
  logic                     fwd_0;
  logic                     fwd_1;
  align_ram_pkg::word_t     fwd_data_0;
  align_ram_pkg::word_t     fwd_data_1;

  write_cache i_write_cache (
    .clk, .rst,
    .write_0, .write_1, .read_0, .read_1,
    .addr_0, .addr_1, .din_0, .din_1,
    .mem_write_0, .mem_write_1, .mem_read_0, .mem_read_1,
    .mem_addr_0, .mem_addr_1,
    .mem_bw_0, .mem_bw_1, .mem_din_0, .mem_din_1,
    .fwd_0, .fwd_1, .fwd_data_0, .fwd_data_1
  );

  row_sram i_row_sram (
    .clk,
    .mem_write_0, .mem_write_1, .mem_read_0, .mem_read_1,
    .mem_addr_0, .mem_addr_1,
    .mem_bw_0, .mem_bw_1, .mem_din_0, .mem_din_1,
    .mem_dout_0, .mem_dout_1
  );

  read_align i_read_align_0 (
    .clk, .rst,
    .read     (read_0),
    .addr     (addr_0),
    .fwd      (fwd_0),
    .fwd_data (fwd_data_0),
    .mem_dout (mem_dout_0),
    .rd_dout  (rd_dout_0),
    .rd_fwrd  (rd_fwrd_0),
    .rd_vld   (rd_vld_0)
  );

  read_align i_read_align_1 (
    .clk, .rst,
    .read     (read_1),
    .addr     (addr_1),
    .fwd      (fwd_1),
    .fwd_data (fwd_data_1),
    .mem_dout (mem_dout_1),
    .rd_dout  (rd_dout_1),
    .rd_fwrd  (rd_fwrd_1),
    .rd_vld   (rd_vld_1)
  );

endmodule

//--- testbench/align_ram_sva.sv
`timescale 1ns/100ps
`include "align_ram_macros.svh"

module align_ram_sva (
  input logic clk,
  input logic rst,
  input logic read_0,
  input logic read_1,
  input logic rd_vld_0,
  input logic rd_vld_1,
  input logic rd_fwrd_0,
  input logic rd_fwrd_1
);

  // Valid is the read strobe seen through the fixed latency
  a_vld_0: assert property (@(posedge clk) disable iff (rst)
    rd_vld_0 == $past(read_0, `ALIGN_SRAM_DELAY))
    else $error("rd_vld_0 does not follow read_0");
  a_vld_1: assert property (@(posedge clk) disable iff (rst)
    rd_vld_1 == $past(read_1, `ALIGN_SRAM_DELAY))
    else $error("rd_vld_1 does not follow read_1");

  a_fwrd_0: assert property (@(posedge clk) disable iff (rst) rd_fwrd_0 |-> rd_vld_0)
    else $error("rd_fwrd_0 high without rd_vld_0");
  a_fwrd_1: assert property (@(posedge clk) disable iff (rst) rd_fwrd_1 |-> rd_vld_1)
    else $error("rd_fwrd_1 high without rd_vld_1");

  a_rst_vld: assert property (@(posedge clk) $fell(rst) |-> !rd_vld_0 && !rd_vld_1)
    else $error("read valid high right after reset");

endmodule

bind align_ram_2rw align_ram_sva i_align_ram_sva (
  .clk, .rst, .read_0, .read_1, .rd_vld_0, .rd_vld_1, .rd_fwrd_0, .rd_fwrd_1
);

//--- testbench/tb_align_ram.sv
`timescale 1ns/100ps
`include "align_ram_macros.svh"

module tb_align_ram;

  localparam int PERIOD = 40;
  localparam int N_RAND = 8;
  localparam int N_B2B  = 12;
  // Reset, the cycles of every test and one drain per test
  localparam int RUN_CYCLES = 9 + 2*N_RAND + 6 + 3 + 6 + 2 + N_B2B + 6*(`ALIGN_SRAM_DELAY + 2);

  logic                 clk = 1'b0;
  logic                 rst = 1'b1;
  logic                 write_0 = 1'b0;
  logic                 read_0 = 1'b0;
  align_ram_pkg::addr_u addr_0 = '0;
  align_ram_pkg::word_t din_0 = '0;
  logic                 write_1 = 1'b0;
  logic                 read_1 = 1'b0;
  align_ram_pkg::addr_u addr_1 = '0;
  align_ram_pkg::word_t din_1 = '0;
  align_ram_pkg::word_t rd_dout_0;
  align_ram_pkg::word_t rd_dout_1;
  logic                 rd_fwrd_0;
  logic                 rd_fwrd_1;
  logic                 rd_vld_0;
  logic                 rd_vld_1;

  align_ram_pkg::word_t model [int];  // Word values by flat address
  logic                 c_vld = 1'b0;  // Expected write cache state
  logic [7:0]           c_row = '0;
  logic [3:0]           c_msk = '0;
  logic [97:0]          exp_q [2][$];  // {due time, care, fwd, data}
  logic [9:0]           wr_list [$];
  logic [31:0]          lfsr = 32'd50;
  int                   errs = 0;
  int                   tests = 0;
  int                   failed = 0;

  align_ram_2rw i_dut (.*);

  always #(PERIOD/2) clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic push_exp(input int p, input logic [9:0] a);
    logic [97:0] e;
    e[31:0]  = model.exists(int'(a)) ? model[int'(a)] : '0;
    e[32]    = c_vld && (a[9:2] == c_row) && c_msk[a[1:0]];
    e[33]    = model.exists(int'(a));
    e[97:34] = $time + (`ALIGN_SRAM_DELAY - 1)*PERIOD + PERIOD/2;  // Negedge of the data cycle
    exp_q[p].push_back(e);
  endtask

  // Deferral, merge and flush of the one row write cache
  task automatic cache_update(input logic w0, input logic r0, input logic [9:0] a0,
                              input logic w1, input logic r1, input logic [9:0] a1);
    logic c0;
    logic c1;
    logic h0;
    logic h1;
    c0 = w0 && r1 && (a0[9:2] == a1[9:2]);
    c1 = w1 && r0 && (a0[9:2] == a1[9:2]);
    h0 = c_vld && (a0[9:2] == c_row);
    h1 = c_vld && (a1[9:2] == c_row);
    if (c0 || c1) begin
      if (!(c0 ? h0 : h1))
        c_msk = '0;
      c_vld = 1'b1;
      c_row = c0 ? a0[9:2] : a1[9:2];
    end
    if (w0 && (c0 || h0))
      c_msk[a0[1:0]] = 1'b1;
    if (w1 && (c1 || h1))
      c_msk[a1[1:0]] = 1'b1;
  endtask

  task automatic do_cycle(input logic w0, input logic r0, input logic [9:0] a0,
                          input align_ram_pkg::word_t d0,
                          input logic w1, input logic r1, input logic [9:0] a1,
                          input align_ram_pkg::word_t d1);
    write_0     = w0;
    read_0      = r0;
    addr_0.flat = a0;
    din_0       = d0;
    write_1     = w1;
    read_1      = r1;
    addr_1.flat = a1;
    din_1       = d1;
    @(posedge clk);
    if (r0)
      push_exp(0, a0);
    if (r1)
      push_exp(1, a1);
    cache_update(w0, r0, a0, w1, r1, a1);
    if (w0)
      model[int'(a0)] = d0;
    if (w1)
      model[int'(a1)] = d1;  // Port 1 lands last on the same word
    #2;
    write_0 = 1'b0;
    read_0  = 1'b0;
    write_1 = 1'b0;
    read_1  = 1'b0;
  endtask

  task automatic check_port(input int p, input logic vld, input logic fwrd,
                            input align_ram_pkg::word_t dout);
    logic        due;
    logic [97:0] e;
    e   = (exp_q[p].size() > 0) ? exp_q[p][0] : '0;
    due = (exp_q[p].size() > 0) && (e[97:34] == $time);
    if (vld !== due) begin
      $display("ERR %0t rd_vld_%0d expected %b got %b", $time, p, due, vld);
      errs++;
    end
    if (due) begin
      void'(exp_q[p].pop_front());
      if (e[33] && dout !== e[31:0]) begin
        $display("ERR %0t rd_dout_%0d expected %h got %h", $time, p, e[31:0], dout);
        errs++;
      end
      if (fwrd !== e[32]) begin
        $display("ERR %0t rd_fwrd_%0d expected %b got %b", $time, p, e[32], fwrd);
        errs++;
      end
    end
  endtask

  // Outputs settle after the rising edge and are sampled half a cycle later
  always @(negedge clk) begin
    if (!rst) begin
      check_port(0, rd_vld_0, rd_fwrd_0, rd_dout_0);
      check_port(1, rd_vld_1, rd_fwrd_1, rd_dout_1);
    end
  end

  task automatic end_test(input string name, input int errs_at_start);
    while (exp_q[0].size() + exp_q[1].size() > 0) begin
      @(posedge clk);
      #2;
    end
    tests++;
    if (errs == errs_at_start) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errs - errs_at_start);
      failed++;
    end
  endtask

  task automatic rand_write_read();
    int         e0;
    logic [9:0] a0;
    logic [9:0] a1;
    e0 = errs;
    for (int i = 0; i < N_RAND; i++) begin
      a0 = 10'(rand_bits(10));
      a1 = {a0[9:2] ^ (8'(rand_bits(8)) | 8'h01), 2'(rand_bits(2))};  // Always another row
      wr_list.push_back(a0);
      wr_list.push_back(a1);
      do_cycle(1'b1, 1'b0, a0, rand_bits(32), 1'b1, 1'b0, a1, rand_bits(32));
      do_cycle(1'b0, 1'b1, a1, '0, 1'b0, 1'b1, a0, '0);
    end
    end_test("random write and read", e0);
  endtask

  task automatic fill_row();
    int e0;
    e0 = errs;
    for (int w = 0; w < `ALIGN_NUMWRDS; w++) begin
      if (w % 2 == 0)
        do_cycle(1'b1, 1'b0, {8'h3C, 2'(w)}, rand_bits(32), 1'b0, 1'b0, '0, '0);
      else
        do_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, {8'h3C, 2'(w)}, rand_bits(32));
    end
    do_cycle(1'b0, 1'b1, {8'h3C, 2'd0}, '0, 1'b0, 1'b1, {8'h3C, 2'd2}, '0);
    do_cycle(1'b0, 1'b1, {8'h3C, 2'd1}, '0, 1'b0, 1'b1, {8'h3C, 2'd3}, '0);
    end_test("row fill", e0);
  endtask

  task automatic read_write_conflict();
    int e0;
    e0 = errs;
    do_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, {8'h55, 2'd0}, rand_bits(32));
    do_cycle(1'b1, 1'b0, {8'h55, 2'd0}, rand_bits(32), 1'b0, 1'b1, {8'h55, 2'd0}, '0);
    do_cycle(1'b0, 1'b1, {8'h55, 2'd0}, '0, 1'b0, 1'b1, {8'h55, 2'd2}, '0);
    end_test("read write conflict", e0);
  endtask

  // Three writes merge into row A0, a conflict on row A1 flushes them
  task automatic merge_and_flush();
    int e0;
    e0 = errs;
    do_cycle(1'b1, 1'b0, {8'hA0, 2'd0}, rand_bits(32), 1'b0, 1'b1, {8'hA0, 2'd3}, '0);
    do_cycle(1'b0, 1'b1, {8'hA0, 2'd3}, '0, 1'b1, 1'b0, {8'hA0, 2'd1}, rand_bits(32));
    do_cycle(1'b1, 1'b0, {8'hA0, 2'd2}, rand_bits(32), 1'b0, 1'b0, '0, '0);
    do_cycle(1'b0, 1'b1, {8'hA1, 2'd0}, '0, 1'b1, 1'b0, {8'hA1, 2'd0}, rand_bits(32));
    do_cycle(1'b0, 1'b1, {8'hA0, 2'd0}, '0, 1'b0, 1'b1, {8'hA0, 2'd1}, '0);
    do_cycle(1'b0, 1'b1, {8'hA0, 2'd2}, '0, 1'b0, 1'b1, {8'hA1, 2'd0}, '0);
    end_test("merge and flush", e0);
  endtask

  task automatic same_row_write();
    int e0;
    e0 = errs;
    do_cycle(1'b1, 1'b0, {8'h0F, 2'd1}, rand_bits(32), 1'b1, 1'b0, {8'h0F, 2'd2}, rand_bits(32));
    do_cycle(1'b0, 1'b1, {8'h0F, 2'd1}, '0, 1'b0, 1'b1, {8'h0F, 2'd2}, '0);
    end_test("same row write", e0);
  endtask

  task automatic back_to_back_reads();
    int e0;
    int n;
    e0 = errs;
    n  = wr_list.size();
    for (int i = 0; i < N_B2B; i++)
      do_cycle(1'b0, 1'b1, wr_list[i % n], '0, 1'b0, 1'b1, wr_list[(i + 5) % n], '0);
    end_test("back to back reads", e0);
  endtask

  initial begin
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    rand_write_read();
    fill_row();
    read_write_conflict();
    merge_and_flush();
    same_row_write();
    back_to_back_reads();
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errs);
    if (errs == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial begin
    #(2 * RUN_CYCLES * PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- build.f
+incdir+rtl
rtl/align_ram_pkg.sv
rtl/write_cache.sv
rtl/row_sram.sv
rtl/read_align.sv
rtl/align_ram_2rw.sv
testbench/align_ram_sva.sv
testbench/tb_align_ram.sv

//--- Makefile
TOP = tb_align_ram

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
